// File: rtl/vid_cfg.svh
`ifndef VID_CFG_SVH
`define VID_CFG_SVH

// Bus command codes
`define VID_CMD_WR_REQ   3'b100
`define VID_CMD_WR_RESP  3'b101
`define VID_CMD_RD_REQ   3'b010
`define VID_CMD_DATA     3'b011

`define VID_LEN_4        2'b10          // Four-beat burst length code
`define VID_BURST_BEATS  4
`define VID_FIFO_DEPTH   32             // Pixel words
`define VID_FIFO_AW      5              // Pointer width for the FIFO depth

// Register offsets
`define VID_OFS_CR       32'h0000_0000
`define VID_OFS_H1       32'h0000_0028
`define VID_OFS_H2       32'h0000_0030
`define VID_OFS_V1       32'h0000_0038
`define VID_OFS_V2       32'h0000_0040
`define VID_OFS_BASE     32'h0000_0048
`define VID_OFS_LINEINC  32'h0000_0050

`endif

// File: rtl/vid_pkg.sv
`default_nettype none

package vid_pkg;

    // Pixel or line position
    typedef logic [12:0] coord_t;

    // Bus address or data word
    typedef logic [31:0] bus_word_t;

    typedef logic [23:0] pixel_t;       // Packed RGB, red in the top byte

    typedef logic [2:0]  cmd_t;         // Bus command code

    typedef logic [5:0]  div_t;         // Pixel clock divider

    // Burst fetch sequencing
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_req,
        fetch_data
    } fetch_state_t;

endpackage

`default_nettype wire

// File: rtl/vid_reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "vid_cfg.svh"

module vid_reg_file (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              sel_in,
    input  wire vid_pkg::cmd_t     cmd_in,
    input  wire vid_pkg::bus_word_t addr_data_in,
    output logic                   en,
    output vid_pkg::div_t          pcnt,
    output vid_pkg::coord_t        hend,
    output vid_pkg::coord_t        hsize,
    output vid_pkg::coord_t        hsync_start,
    output vid_pkg::coord_t        hsync_end,
    output vid_pkg::coord_t        vend,
    output vid_pkg::coord_t        vsize,
    output vid_pkg::coord_t        vsync_start,
    output vid_pkg::coord_t        vsync_end,
    output vid_pkg::bus_word_t     base_address,
    output vid_pkg::bus_word_t     line_inc,
    output logic                   wr_resp
);

    vid_pkg::bus_word_t addr_q;
    logic               wr_req_hit;

    // A data cycle is never taken as a new request
    assign wr_req_hit = sel_in && (cmd_in == `VID_CMD_WR_REQ) && !wr_resp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_resp <= 1'b0;
            en      <= 1'b0;
        end else begin
            wr_resp <= wr_req_hit;      // High during the data cycle
            if (wr_resp && (addr_q == `VID_OFS_CR)) begin
                en <= addr_data_in[3];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req_hit) begin
            addr_q <= addr_data_in;     // Address phase
        end
        if (wr_resp) begin
            case (addr_q)
                `VID_OFS_CR:      pcnt <= addr_data_in[9:4];
                `VID_OFS_H1: begin
                    hend  <= addr_data_in[12:0];
                    hsize <= addr_data_in[25:13];
                end
                `VID_OFS_H2: begin
                    hsync_start <= addr_data_in[25:13];
                    hsync_end   <= addr_data_in[12:0];
                end
                `VID_OFS_V1: begin
                    vend  <= addr_data_in[12:0];
                    vsize <= addr_data_in[25:13];
                end
                `VID_OFS_V2: begin
                    vsync_start <= addr_data_in[25:13];
                    vsync_end   <= addr_data_in[12:0];
                end
                `VID_OFS_BASE:    base_address <= addr_data_in;
                `VID_OFS_LINEINC: line_inc     <= addr_data_in;
                default: ;                      // Unknown offset ignored
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/vid_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vid_timing (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            en,
    input  wire vid_pkg::div_t   pcnt,
    input  wire vid_pkg::coord_t hend,
    input  wire vid_pkg::coord_t hsize,
    input  wire vid_pkg::coord_t hsync_start,
    input  wire vid_pkg::coord_t hsync_end,
    input  wire vid_pkg::coord_t vend,
    input  wire vid_pkg::coord_t vsize,
    input  wire vid_pkg::coord_t vsync_start,
    input  wire vid_pkg::coord_t vsync_end,
    output logic                 hsync,
    output logic                 hblank,
    output logic                 vsync,
    output logic                 vblank,
    output logic                 pop
);

    vid_pkg::div_t   div_cnt;
    vid_pkg::coord_t h_count;
    vid_pkg::coord_t v_count;
    logic            pixel_tick;
    logic            h_active;
    logic            v_active;

    assign pixel_tick = en && (div_cnt == pcnt);    // One every pcnt+1 clocks
    assign h_active   = (h_count < hsize);
    assign v_active   = (v_count < vsize);
    assign pop        = pixel_tick && h_active && v_active;

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            div_cnt <= '0;
            h_count <= '0;
            v_count <= '0;
            hsync   <= 1'b0;
            hblank  <= 1'b0;
            vsync   <= 1'b0;
            vblank  <= 1'b0;
        end else if (pixel_tick) begin
            div_cnt <= '0;
            // Outputs describe the position just ticked
            hblank  <= !h_active;
            vblank  <= !v_active;
            hsync   <= (h_count >= hsync_start) && (h_count < hsync_end);
            vsync   <= (v_count >= vsync_start) && (v_count < vsync_end);
            if (h_count == hend) begin
                h_count <= '0;
                if (v_count == vend) begin
                    v_count <= '0;              // Frame wrap
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vid_fetch_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "vid_cfg.svh"

module vid_fetch_fsm (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               en,
    input  wire vid_pkg::bus_word_t base_address,
    input  wire vid_pkg::bus_word_t line_inc,
    input  wire vid_pkg::coord_t    hsize,
    input  wire vid_pkg::coord_t    vsize,
    input  wire logic               wr_resp,
    input  wire vid_pkg::cmd_t      cmd_in,
    input  wire vid_pkg::bus_word_t addr_data_in,
    input  wire logic               ack_in,
    input  wire logic [`VID_FIFO_AW:0] free_count,
    output logic                    req_out,
    output vid_pkg::cmd_t           cmd_out,
    output logic [1:0]              len_out,
    output vid_pkg::bus_word_t      addr_data_out,
    output logic                    push,
    output vid_pkg::bus_word_t      push_data
);

    vid_pkg::fetch_state_t state;
    vid_pkg::coord_t       word_pos;        // First word of the next burst
    vid_pkg::coord_t       line_pos;
    vid_pkg::bus_word_t    line_addr;       // Start address of the current line
    logic [1:0]            beat_cnt;
    logic                  last_beat;
    vid_pkg::bus_word_t    burst_addr;

    assign burst_addr = line_addr + {17'd0, word_pos, 2'b00};
    assign push       = (state == vid_pkg::fetch_data) && (cmd_in == `VID_CMD_DATA);
    assign push_data  = addr_data_in;
    assign last_beat  = push && (beat_cnt == 2'(`VID_BURST_BEATS - 1));

    // Write response takes priority on the command lines
    assign req_out       = (state == vid_pkg::fetch_req);
    assign len_out       = req_out ? `VID_LEN_4 : 2'b00;
    assign addr_data_out = req_out ? burst_addr : '0;
    assign cmd_out       = wr_resp ? `VID_CMD_WR_RESP :
                           (req_out ? `VID_CMD_RD_REQ : 3'b000);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= vid_pkg::fetch_idle;
            word_pos  <= '0;
            line_pos  <= '0;
            line_addr <= '0;
            beat_cnt  <= '0;
        end else begin
            case (state)
                vid_pkg::fetch_idle: begin
                    if (!en) begin
                        word_pos  <= '0;                // Hold at frame start
                        line_pos  <= '0;
                        line_addr <= base_address;
                    end else if (free_count >= (`VID_FIFO_AW + 1)'(`VID_BURST_BEATS)) begin
                        state <= vid_pkg::fetch_req;
                    end
                end
                vid_pkg::fetch_req: begin
                    beat_cnt <= '0;
                    if (ack_in) begin
                        state <= vid_pkg::fetch_data;
                    end
                end
                vid_pkg::fetch_data: begin
                    if (push) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= vid_pkg::fetch_idle;
                        if (word_pos + vid_pkg::coord_t'(`VID_BURST_BEATS) >= hsize) begin
                            word_pos <= '0;
                            if (line_pos == vsize - 1'b1) begin
                                line_pos  <= '0;        // Back to the first line
                                line_addr <= base_address;
                            end else begin
                                line_pos  <= line_pos + 1'b1;
                                line_addr <= line_addr + line_inc;
                            end
                        end else begin
                            word_pos <= word_pos + vid_pkg::coord_t'(`VID_BURST_BEATS);
                        end
                    end
                end
                default: state <= vid_pkg::fetch_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/vid_line_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "vid_cfg.svh"

module vid_line_fifo (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               push,
    input  wire vid_pkg::bus_word_t push_data,
    input  wire logic               pop,
    output logic [`VID_FIFO_AW:0]   free_count,
    output logic [7:0]              r,
    output logic [7:0]              g,
    output logic [7:0]              b
);

    vid_pkg::bus_word_t         mem [`VID_FIFO_DEPTH];
    logic [`VID_FIFO_AW-1:0]    wr_ptr;
    logic [`VID_FIFO_AW-1:0]    rd_ptr;
    logic [`VID_FIFO_AW:0]      count;
    logic                       pop_ok;
    vid_pkg::pixel_t            pix_q;

    assign pop_ok     = pop && (count != '0);   // Empty pop leaves the pointers alone
    assign free_count = (`VID_FIFO_AW + 1)'(`VID_FIFO_DEPTH) - count;
    assign r          = pix_q[23:16];
    assign g          = pix_q[15:8];
    assign b          = pix_q[7:0];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pix_q  <= '0;
        end else begin
            wr_ptr <= wr_ptr + {{(`VID_FIFO_AW-1){1'b0}}, push};
            rd_ptr <= rd_ptr + {{(`VID_FIFO_AW-1){1'b0}}, pop_ok};
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            pix_q <= pop_ok ? mem[rd_ptr][23:0] : '0;   // Black outside active pixels
        end
    end

endmodule

`default_nettype wire

// File: rtl/vid_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "vid_cfg.svh"

module vid_ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               sel_in,
    input  wire vid_pkg::cmd_t      cmd_in,
    input  wire logic [1:0]         len_in,     // Bus compatibility only
    input  wire vid_pkg::bus_word_t addr_data_in,
    input  wire logic               ack_in,
    output logic                    req_out,
    output logic [1:0]              len_out,
    output vid_pkg::bus_word_t      addr_data_out,
    output vid_pkg::cmd_t           cmd_out,
    output logic                    hsync,
    output logic                    hblank,
    output logic                    vsync,
    output logic                    vblank,
    output logic [7:0]              r,
    output logic [7:0]              g,
    output logic [7:0]              b
);

    logic                  en;
    logic                  wr_resp;
    logic                  pop;
    logic                  push;
    vid_pkg::div_t         pcnt;
    vid_pkg::coord_t       hend, hsize, hsync_start, hsync_end;
    vid_pkg::coord_t       vend, vsize, vsync_start, vsync_end;
    vid_pkg::bus_word_t    base_address;
    vid_pkg::bus_word_t    line_inc;
    vid_pkg::bus_word_t    push_data;
    logic [`VID_FIFO_AW:0] free_count;

    vid_reg_file u_reg_file (
        .clk, .rst_n, .sel_in, .cmd_in, .addr_data_in,
        .en, .pcnt, .hend, .hsize, .hsync_start, .hsync_end,
        .vend, .vsize, .vsync_start, .vsync_end,
        .base_address, .line_inc, .wr_resp
    );

    vid_timing u_timing (
        .clk, .rst_n, .en, .pcnt, .hend, .hsize, .hsync_start, .hsync_end,
        .vend, .vsize, .vsync_start, .vsync_end,
        .hsync, .hblank, .vsync, .vblank, .pop
    );

    vid_fetch_fsm u_fetch_fsm (
        .clk, .rst_n, .en, .base_address, .line_inc, .hsize, .vsize, .wr_resp,
        .cmd_in, .addr_data_in, .ack_in, .free_count,
        .req_out, .cmd_out, .len_out, .addr_data_out, .push, .push_data
    );

    vid_line_fifo u_line_fifo (
        .clk, .rst_n, .push, .push_data, .pop, .free_count, .r, .g, .b
    );

endmodule

`default_nettype wire

// File: verification/vid_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "vid_cfg.svh"

module vid_ctrl_checker (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               video_on,
    input  wire vid_pkg::div_t      pcnt,
    input  wire vid_pkg::coord_t    hend,
    input  wire vid_pkg::coord_t    hsize,
    input  wire vid_pkg::coord_t    hsync_start,
    input  wire vid_pkg::coord_t    hsync_end,
    input  wire vid_pkg::coord_t    vend,
    input  wire vid_pkg::coord_t    vsize,
    input  wire vid_pkg::coord_t    vsync_start,
    input  wire vid_pkg::coord_t    vsync_end,
    input  wire vid_pkg::bus_word_t base_address,
    input  wire vid_pkg::bus_word_t line_inc,
    input  wire logic               sel_in,
    input  wire vid_pkg::cmd_t      cmd_in,
    input  wire vid_pkg::bus_word_t addr_data_in,
    input  wire logic               ack_in,
    input  wire logic               req_out,
    input  wire vid_pkg::cmd_t      cmd_out,
    input  wire logic [1:0]         len_out,
    input  wire vid_pkg::bus_word_t addr_data_out,
    input  wire logic               hsync,
    input  wire logic               hblank,
    input  wire logic               vsync,
    input  wire logic               vblank,
    input  wire logic [7:0]         r,
    input  wire logic [7:0]         g,
    input  wire logic [7:0]         b,
    output int                      mismatch_count,
    output int                      failure_count,
    output int                      pixels_checked
);

    int                 cycle_idx;                  // Cycles since en took effect
    logic               en_seen;
    logic               wr_req_q;
    logic               req_waiting;
    int                 line_idx;                   // Next burst position
    int                 word_idx;
    vid_pkg::bus_word_t pixel_q [$];                // Words delivered on the bus, in order

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t",
                     name, actual, expected, $time);
            mismatch_count++;
        end
    endtask

    always @(posedge clk) begin : compare
        int                 period;
        int                 k;
        int                 h;
        int                 v;
        logic               e_hblank;
        logic               e_hsync;
        logic               e_vblank;
        logic               e_vsync;
        vid_pkg::bus_word_t e_rgb;
        vid_pkg::bus_word_t e_addr;
        vid_pkg::bus_word_t word;
        vid_pkg::cmd_t      e_cmd;

        period   = int'(pcnt) + 1;
        e_hblank = 1'b0;
        e_hsync  = 1'b0;
        e_vblank = 1'b0;
        e_vsync  = 1'b0;
        e_rgb    = '0;
        e_addr   = base_address + line_inc * line_idx + 4 * word_idx;
        if (!rst_n) begin
            en_seen     <= 1'b0;
            cycle_idx   <= 0;
            wr_req_q    <= 1'b0;
            req_waiting <= 1'b0;
            line_idx    <= 0;
            word_idx    <= 0;
        end else begin
            if (en_seen && cycle_idx >= period) begin
                k = cycle_idx / period - 1;                         // Latest pixel tick
                h = k % (int'(hend) + 1);
                v = (k / (int'(hend) + 1)) % (int'(vend) + 1);
                e_hblank = (h >= int'(hsize));
                e_hsync  = (h >= int'(hsync_start)) && (h < int'(hsync_end));
                e_vblank = (v >= int'(vsize));
                e_vsync  = (v >= int'(vsync_start)) && (v < int'(vsync_end));
                if ((cycle_idx % period == 0) && !e_hblank && !e_vblank) begin
                    if (pixel_q.size() == 0) begin
                        $display("Pixel %0d is due before its word came over the bus",
                                 pixels_checked);
                        failure_count++;
                    end else begin
                        word  = pixel_q.pop_front();
                        e_rgb = {8'h00, word[23:0]};
                    end
                    pixels_checked++;
                end
            end
            e_cmd = wr_req_q ? `VID_CMD_WR_RESP : (req_out ? `VID_CMD_RD_REQ : 3'b000);
            if (!en_seen && req_out) begin
                $display("Read request issued while the controller is disabled");
                failure_count++;
            end
            if (req_waiting && !req_out) begin
                $display("Read request withdrawn before it was acknowledged");
                failure_count++;
            end
            check_value("cmd_out", 32'(cmd_out), 32'(e_cmd));
            check_value("len_out", 32'(len_out), req_out ? 32'(`VID_LEN_4) : 32'h0);
            check_value("addr_data_out", addr_data_out, req_out ? e_addr : 32'h0);
            check_value("hsync", 32'(hsync), 32'(e_hsync));
            check_value("hblank", 32'(hblank), 32'(e_hblank));
            check_value("vsync", 32'(vsync), 32'(e_vsync));
            check_value("vblank", 32'(vblank), 32'(e_vblank));
            check_value("rgb", {8'h00, r, g, b}, e_rgb);
            if (req_out && ack_in) begin
                if (word_idx + `VID_BURST_BEATS >= int'(hsize)) begin
                    word_idx <= 0;
                    line_idx <= (line_idx + 1 == int'(vsize)) ? 0 : line_idx + 1;
                end else begin
                    word_idx <= word_idx + `VID_BURST_BEATS;
                end
            end
            if (cmd_in == `VID_CMD_DATA) begin
                pixel_q.push_back(addr_data_in);
            end
            wr_req_q    <= sel_in && (cmd_in == `VID_CMD_WR_REQ);
            req_waiting <= req_out && !ack_in;
            if (en_seen) begin
                cycle_idx <= cycle_idx + 1;
            end else if (video_on) begin
                en_seen   <= 1'b1;                      // en is set at this edge
                cycle_idx <= 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/vid_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "vid_cfg.svh"

module vid_ctrl_tb;

    localparam int NUM_WRITES = 7;
    localparam int PIX_BASE   = 2 * NUM_WRITES;     // First pixel word in the data file
    localparam int NUM_PIX    = 32;

    logic               clk;
    logic               rst_n;
    logic               sel_in;
    vid_pkg::cmd_t      cmd_in;
    logic [1:0]         len_in;
    vid_pkg::bus_word_t addr_data_in;
    logic               ack_in;
    logic               req_out;
    logic [1:0]         len_out;
    vid_pkg::bus_word_t addr_data_out;
    vid_pkg::cmd_t      cmd_out;
    logic               hsync;
    logic               hblank;
    logic               vsync;
    logic               vblank;
    logic [7:0]         r;
    logic [7:0]         g;
    logic [7:0]         b;
    logic               video_on;                   // Set when the enable bit is written
    vid_pkg::bus_word_t stim [PIX_BASE + NUM_PIX];
    vid_pkg::div_t      pcnt;
    vid_pkg::coord_t    hend;
    vid_pkg::coord_t    hsize;
    vid_pkg::coord_t    hsync_start;
    vid_pkg::coord_t    hsync_end;
    vid_pkg::coord_t    vend;
    vid_pkg::coord_t    vsize;
    vid_pkg::coord_t    vsync_start;
    vid_pkg::coord_t    vsync_end;
    vid_pkg::bus_word_t base_address;
    vid_pkg::bus_word_t line_inc;
    int                 mismatch_count;
    int                 failure_count;
    int                 pixels_checked;
    int                 cycle_count;
    int                 timeout_limit;
    int                 next_word;

    vid_ctrl dut0 (.*);

    vid_ctrl_checker checker0 (.*);

    always #20 clk = ~clk;

    // Field layout of the register words
    task automatic decode_write(input vid_pkg::bus_word_t addr, input vid_pkg::bus_word_t data);
        case (addr)
            `VID_OFS_CR:      pcnt = data[9:4];
            `VID_OFS_H1: begin
                hend  = data[12:0];
                hsize = data[25:13];
            end
            `VID_OFS_H2: begin
                hsync_start = data[25:13];
                hsync_end   = data[12:0];
            end
            `VID_OFS_V1: begin
                vend  = data[12:0];
                vsize = data[25:13];
            end
            `VID_OFS_V2: begin
                vsync_start = data[25:13];
                vsync_end   = data[12:0];
            end
            `VID_OFS_BASE:    base_address = data;
            `VID_OFS_LINEINC: line_inc     = data;
            default: ;
        endcase
    endtask

    task automatic write_register(input vid_pkg::bus_word_t addr, input vid_pkg::bus_word_t data);
        @(negedge clk);
        sel_in       = 1'b1;                        // Address phase
        cmd_in       = `VID_CMD_WR_REQ;
        addr_data_in = addr;
        @(negedge clk);
        sel_in       = 1'b0;                        // Data phase
        cmd_in       = '0;
        addr_data_in = data;
        if (addr == `VID_OFS_CR) begin
            video_on = data[3];
        end
        @(negedge clk);
        addr_data_in = '0;
    endtask

    // Ack after a random gap, then return four words from the list
    task automatic serve_burst();
        int unsigned delay;
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        ack_in = 1'b1;
        @(negedge clk);
        ack_in = 1'b0;
        repeat (`VID_BURST_BEATS) begin
            cmd_in       = `VID_CMD_DATA;
            addr_data_in = stim[PIX_BASE + next_word];
            next_word    = (next_word + 1) % NUM_PIX;
            @(negedge clk);
        end
        cmd_in       = '0;
        addr_data_in = '0;
    endtask

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures (%0d pixels checked)",
                 mismatch_count, failure_count, pixels_checked);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles before the frames were checked", cycle_count);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin : main
        clk          = 1'b0;
        rst_n        = 1'b0;
        sel_in       = 1'b0;
        cmd_in       = '0;
        len_in       = '0;
        addr_data_in = '0;
        ack_in       = 1'b0;
        video_on     = 1'b0;
        next_word    = 0;
        void'($urandom(32'hd5fbe5c5));
        $readmemh("verification/vid_ctrl_input.txt", stim);
        for (int i = 0; i < NUM_WRITES; i++) begin
            decode_write(stim[2 * i], stim[2 * i + 1]);
        end
        // Three frames of run time plus setup margin
        timeout_limit = 3 * (int'(hend) + 1) * (int'(vend) + 1) * (int'(pcnt) + 1) + 200;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);                  // Idle while disabled
        for (int i = 0; i < NUM_WRITES; i++) begin
            write_register(stim[2 * i], stim[2 * i + 1]);
        end
        while (pixels_checked < 2 * int'(hsize) * int'(vsize)) begin
            @(negedge clk);
            if (req_out) begin
                serve_burst();
            end
        end
        report_counts();
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/vid_ctrl_input.txt
// Words 0-13: seven register writes, each as a register offset followed by its data word
// Words 14-45: pixel words the bus returns in burst order, RGB in the low 24 bits
00000028 0001000B
00000030 0001200A
00000038 00008005
00000040 00008005
00000048 10000000
00000050 00000100
00000000 00000078
FF000000 00FF0000 0000FF00 000000FF 11223344 55667788 99AABBCC DDEEFF00
01020304 05060708 090A0B0C 0D0E0F10 A0B0C0D0 E0F00010 12345678 9ABCDEF0
00808080 7F7F7F7F 00102030 00405060 00708090 00A0B0C0 00D0E0F0 00FFFFFF
C0A0E000 00B0D050 00DEC0DE 00F00D00 00ACE123 00B0B0B0 00C0C0C0 00E1E2E3

// File: vid_ctrl.f
+incdir+rtl
rtl/vid_pkg.sv
rtl/vid_reg_file.sv
rtl/vid_timing.sv
rtl/vid_fetch_fsm.sv
rtl/vid_line_fifo.sv
rtl/vid_ctrl.sv
verification/vid_ctrl_checker.sv
verification/vid_ctrl_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := vid_ctrl_tb
FILELIST   := vid_ctrl.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
